// File: icache_pkg.sv
package icache_pkg;

    // address split, 32-bit byte address
    localparam int OFFSET_W       = 4;   // 16 bytes per line
    localparam int INDEX_W        = 8;   // 256 lines
    localparam int TAG_W          = 20;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 1 << INDEX_W;
    localparam int LINE_W         = WORDS_PER_LINE * 32;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_s;

    // fetch side writes raw, cache side reads the fields
    typedef union packed {
        logic [31:0] raw;
        fetch_addr_s fields;
    } fetch_addr_u;

    typedef struct packed {
        logic        valid;  // one-cycle strobe
        fetch_addr_u addr;
    } fetch_req_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_rsp_s;

    typedef struct packed {
        logic        req;   // level, held in MISS
        logic [31:0] addr;  // line address, offset zero
    } refill_req_s;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;  // word 0 in the low bits
    } refill_ret_s;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tagv_s;

endpackage

// File: tag_ram.sv
`timescale 1ns/10ps

module tag_ram (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  icache_pkg::tagv_s            wdata,
    output icache_pkg::tagv_s            rdata
);
    import icache_pkg::*;

    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;  // kept apart so reset can clear it

    // tag array, no reset
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[addr] <= wdata.tag;
        end
    end

    // valid bits and the read register
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;      // cold cache, every lookup misses
            rdata   <= '0;
        end else begin
            if (we) begin
                valid_q[addr] <= wdata.valid;
            end
            rdata.tag   <= tag_mem[addr];   // old entry during a write
            rdata.valid <= valid_q[addr];
        end
    end

endmodule

// File: line_bank.sv
`timescale 1ns/10ps

module line_bank (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic                           rd_en,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  logic [31:0]                    wdata,
    output logic [31:0]                    rdata
);
    import icache_pkg::*;

    logic [31:0] mem [NUM_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    // read register holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[addr];  // no bypass, a same-cycle write is not seen
        end
    end

endmodule

// File: icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::fetch_req_s  fetch_req,
    output logic                    busy,
    output icache_pkg::fetch_rsp_s  fetch_rsp,
    output icache_pkg::refill_req_s refill_req,
    input  logic                    refill_rdy,
    input  icache_pkg::refill_ret_s refill_ret
);
    import icache_pkg::*;

    localparam logic [1:0] LOOKUP     = 2'd0;
    localparam logic [1:0] MISS       = 2'd1;
    localparam logic [1:0] REFILL     = 2'd2;
    localparam logic [1:0] REFILLDONE = 2'd3;

    localparam int SEL_W = $clog2(WORDS_PER_LINE);

    logic [1:0] state_q;
    logic [1:0] state_d;

    // request buffer
    logic        buf_valid_q;
    fetch_addr_u buf_addr_q;
    logic        hit_q;        // buffered request already delivered

    logic               pending;
    logic               tag_hit;
    logic               rsp_fire;
    logic [INDEX_W-1:0] ram_index;
    logic               fill_we;
    logic               bank_rd_en;
    tagv_s              tagv_rdata;
    tagv_s              tagv_wdata;
    fetch_addr_u        line_addr;
    logic [SEL_W-1:0]   word_sel;
    logic [31:0]        bank_rdata [WORDS_PER_LINE];

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid_q <= 1'b0;
            hit_q       <= 1'b0;
        end else if (fetch_req.valid) begin
            buf_valid_q <= 1'b1;
            hit_q       <= 1'b0;
        end else if (rsp_fire) begin
            hit_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req.valid) begin
            buf_addr_q <= fetch_req.addr;
        end
    end

    // hit detection against the registered tag read
    assign pending  = buf_valid_q & ~hit_q;
    assign tag_hit  = tagv_rdata.valid & (tagv_rdata.tag == buf_addr_q.fields.tag);
    assign rsp_fire = (state_q == LOOKUP) & pending & tag_hit;
    assign busy     = (state_q != LOOKUP) | (pending & ~tag_hit);

    // RAM control
    assign ram_index  = (state_q == LOOKUP) ? fetch_req.addr.fields.index
                                            : buf_addr_q.fields.index;
    assign fill_we    = (state_q == REFILL) & refill_ret.valid;
    assign bank_rd_en = ((state_q == LOOKUP) & fetch_req.valid) | (state_q == REFILLDONE);

    always_comb begin
        tagv_wdata.tag   = buf_addr_q.fields.tag;
        tagv_wdata.valid = 1'b1;
    end

    tag_ram u_tag_ram (
        .clk   (clk),
        .reset (reset),
        .we    (fill_we),
        .addr  (ram_index),
        .wdata (tagv_wdata),
        .rdata (tagv_rdata)
    );

    // one bank per word of the line
    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_bank
        line_bank u_bank (
            .clk   (clk),
            .wr_en (fill_we),
            .rd_en (bank_rd_en),
            .addr  (ram_index),
            .wdata (refill_ret.data[32*w +: 32]),
            .rdata (bank_rdata[w])
        );
    end

    // refill port
    always_comb begin
        line_addr               = buf_addr_q;
        line_addr.fields.offset = '0;
        refill_req.req          = (state_q == MISS);
        refill_req.addr         = line_addr.raw;
    end

    // word select and response
    assign word_sel = buf_addr_q.fields.offset[OFFSET_W-1:2];

    always_comb begin
        fetch_rsp.valid = rsp_fire;
        fetch_rsp.pc    = buf_addr_q.raw;
        fetch_rsp.instr = bank_rdata[word_sel];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (pending && !tag_hit) begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (refill_rdy) begin  // address accepted by memory
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (refill_ret.valid) begin
                    state_d = REFILLDONE;
                end
            end
            REFILLDONE: begin
                state_d = LOOKUP;    // banks re-read this cycle
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   busy,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc,
    output icache_pkg::fetch_req_s fetch_req
);
    import icache_pkg::*;

    localparam logic [31:0] PC_STEP = 32'd4;

    fetch_addr_u pc_q;   // address of the next request
    logic        issue;

    // one request per cycle while the cache accepts
    assign issue = ~busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q.raw <= RESET_PC;
        end else if (redirect) begin
            pc_q.raw <= redirect_pc;      // wins over the step, even when busy
        end else if (issue) begin
            pc_q.raw <= pc_q.raw + PC_STEP;
        end
    end

    always_comb begin
        fetch_req.valid = issue;
        fetch_req.addr  = pc_q;
    end

endmodule

// File: ifetch_top.sv
`timescale 1ns/10ps

module ifetch_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    redirect,
    input  logic [31:0]             redirect_pc,
    output icache_pkg::refill_req_s refill_req,
    input  logic                    refill_rdy,
    input  icache_pkg::refill_ret_s refill_ret,
    output icache_pkg::fetch_rsp_s  fetch_rsp
);
    import icache_pkg::*;

    fetch_req_s fetch_req;
    logic       busy;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .busy        (busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req)
    );

    icache u_icache (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .busy       (busy),
        .fetch_rsp  (fetch_rsp),
        .refill_req (refill_req),
        .refill_rdy (refill_rdy),
        .refill_ret (refill_ret)
    );

endmodule

// File: ifetch_sva.sv
`timescale 1ns/10ps

module ifetch_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    in_refill,
    input logic                    busy,
    input logic                    refill_rdy,
    input icache_pkg::refill_req_s refill_req,
    input icache_pkg::refill_ret_s refill_ret,
    input icache_pkg::fetch_rsp_s  fetch_rsp
);

    // memory may take the line address any time until rdy
    property refill_addr_stable;
        @(posedge clk) disable iff (reset)
            refill_req.req && !refill_rdy |=> $stable(refill_req.addr);
    endproperty

    property ret_only_in_refill;
        @(posedge clk) disable iff (reset)
            refill_ret.valid |-> in_refill;
    endproperty

    // a miss ends only with its word on the output
    property busy_ends_with_rsp;
        @(posedge clk) disable iff (reset)
            $fell(busy) |-> fetch_rsp.valid;
    endproperty

    property quiet_after_reset;
        @(posedge clk) reset |=> !refill_req.req && !busy && !fetch_rsp.valid;
    endproperty

    a_refill_addr_stable: assert property (refill_addr_stable)
        else $error("refill address changed while waiting for refill_rdy");
    a_ret_only_in_refill: assert property (ret_only_in_refill)
        else $error("refill return strobe outside the REFILL state");
    a_busy_ends_with_rsp: assert property (busy_ends_with_rsp)
        else $error("busy dropped without an instruction delivered");
    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("refill request, busy or response active right after reset");

endmodule

bind icache ifetch_sva u_ifetch_sva (
    .clk        (clk),
    .reset      (reset),
    .in_refill  (state_q == REFILL),
    .busy       (busy),
    .refill_rdy (refill_rdy),
    .refill_req (refill_req),
    .refill_ret (refill_ret),
    .fetch_rsp  (fetch_rsp)
);

// File: tb_ifetch.sv
`timescale 1ns/10ps

module tb_ifetch;
    import icache_pkg::*;

    localparam logic [31:0] RESET_PC       = 32'h0000_1000;
    localparam int          TEST_LEN       = 4 + 64 + 24 + 40;  // instructions over all tests
    localparam int          TIMEOUT_CYCLES = TEST_LEN * 20;

    logic        clk;
    logic        reset;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        refill_rdy;
    refill_req_s refill_req;
    refill_ret_s refill_ret;
    fetch_rsp_s  fetch_rsp;

    logic [31:0] lfsr_q     = 32'hc4bc7965;
    logic        stall_mode = 1'b0;  // long refill_rdy stretches
    string       test_name  = "reset";
    int          mismatch_count = 0;
    int          other_count    = 0;

    // expected pc stream in issue order
    logic [31:0] exp_pc_q[$];
    logic [31:0] next_pc           = RESET_PC;
    logic        first_issue       = 1'b1;
    logic [31:0] last_pc           = '0;
    logic [31:0] first_refill_addr = '0;
    int          deliveries        = 0;
    int          refills           = 0;
    int          cycle_count       = 0;

    ifetch_top DUT (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .refill_req  (refill_req),
        .refill_rdy  (refill_rdy),
        .refill_ret  (refill_ret),
        .fetch_rsp   (fetch_rsp)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);  // one step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // program image word at byte address a
    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ 32'h9e37_79b9;
        x = x ^ {x[26:0], x[31:27]};
        x = x ^ {x[18:0], x[31:19]};
        return x;
    endfunction

    function automatic logic [LINE_W-1:0] line_data(input logic [31:0] line_addr);
        logic [LINE_W-1:0] d;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            d[32*w +: 32] = ref_word(line_addr + 32'(w * 4));
        end
        return d;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;  // drive point
    endtask

    task automatic wait_deliveries(input int n);
        while (deliveries < n) begin
            wait_cycle();
        end
    endtask

    task automatic wait_for_pc(input logic [31:0] pc);
        while (last_pc != pc) begin
            wait_cycle();
        end
    endtask

    task automatic pulse_redirect(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        wait_cycle();
        redirect    = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES + 8) @(posedge clk);
        $display("timeout: no result after %0d cycles, the fetch stream stalled",
                 TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // refill memory with rdy after 0..3 cycles (more when stalling) and the line 1..4 cycles later
    initial begin : memory_model
        int unsigned delay;
        int unsigned gap;
        logic [31:0] addr;
        refill_rdy = 1'b0;
        refill_ret = '0;
        forever begin
            wait_cycle();
            if (refill_req.req) begin
                addr  = refill_req.addr;
                delay = rand_bits(2);
                if (stall_mode) begin
                    delay = delay + rand_bits(4);
                end
                repeat (delay) wait_cycle();
                refill_rdy = 1'b1;
                wait_cycle();          // accepted at this edge
                refill_rdy = 1'b0;
                gap = rand_bits(2);
                repeat (gap) wait_cycle();
                refill_ret.data  = line_data(addr);
                refill_ret.valid = 1'b1;
                wait_cycle();
                refill_ret.valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare_proc
        logic [31:0] exp_pc;
        logic        issued;
        cycle_count++;
        if (reset) begin
            next_pc     = RESET_PC;
            first_issue = 1'b1;
        end else begin
            if (refill_req.req && refill_rdy) begin
                if (refills == 0) begin
                    first_refill_addr = refill_req.addr;
                end
                refills++;
            end
            if (fetch_rsp.valid) begin
                if (exp_pc_q.size() == 0) begin
                    other_count++;
                    $display("ERROR %s: instruction at pc %h delivered with no request pending",
                             test_name, fetch_rsp.pc);
                end else begin
                    exp_pc = exp_pc_q.pop_front();
                    check_value("pc", exp_pc, fetch_rsp.pc);
                    check_value("instr", ref_word(exp_pc), fetch_rsp.instr);
                    last_pc = exp_pc;
                end
                deliveries++;
            end
            // a request issues in every cycle the cache is free
            issued      = fetch_rsp.valid | first_issue;
            first_issue = 1'b0;
            if (issued) begin
                exp_pc_q.push_back(next_pc);
            end
            if (redirect) begin
                next_pc = redirect_pc;
            end else if (issued) begin
                next_pc = next_pc + 32'd4;
            end
        end
    end

    initial begin : stimulus
        int snap;
        int hit_start;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "cold_start";
        wait_deliveries(1);
        hit_start = cycle_count;
        check_value("refill_count", 32'd1, refills);
        check_value("refill_addr", RESET_PC & ~32'hf, first_refill_addr);

        test_name = "line_hits";
        wait_deliveries(4);
        check_value("hit_cycles", 32'd3, cycle_count - hit_start);
        check_value("refill_count", 32'd1, refills);

        test_name = "sequential";
        snap = refills;
        wait_deliveries(4 + 64);
        check_value("refill_count", snap + 64 / WORDS_PER_LINE, refills);

        test_name = "redirect";
        pulse_redirect(32'h0000_1020);   // earlier and cached
        wait_for_pc(32'h0000_1110);      // in-flight miss still delivered
        snap = refills;
        wait_for_pc(32'h0000_103c);
        check_value("cached_refills", snap, refills);
        snap = refills;
        pulse_redirect(32'h0000_2020);   // same index with a new tag
        wait_for_pc(32'h0000_2020);
        check_value("evict_refills", snap + 1, refills);
        pulse_redirect(32'h0000_1020);   // evicted so it refills again
        wait_for_pc(32'h0000_1020);
        check_value("reload_refills", snap + 2, refills);

        test_name  = "back_pressure";
        stall_mode = 1'b1;
        snap       = refills;
        pulse_redirect(32'h0000_3000);
        wait_for_pc(32'h0000_307c);
        check_value("refill_count", snap + 8, refills);
        stall_mode = 1'b0;

        $display("checks finished: %0d mismatches, %0d other errors",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: ifetch_top.f
icache_pkg.sv
tag_ram.sv
line_bank.sv
icache.sv
fetch_unit.sv
ifetch_top.sv
ifetch_sva.sv
tb_ifetch.sv

// File: run.sh
#!/bin/sh
# build and run the instruction fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_ifetch_sim

rm -rf obj_dir
verilator --binary --timing --assert -f ifetch_top.f --top-module tb_ifetch -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
